// File: bench/posit_mac_chk.sv
module posit_mac_chk
    import posit_pkg::*;
(
    input logic   clk_i,
    input logic   rstn,
    input logic   in_vld_i,
    input logic   dec_vld_i,
    input logic   mul_vld_i,
    input logic   out_vld_i,
    input posit_t acc_i
);

    // result strobe is a single-cycle pulse
    a_single_pulse: assert property (@(posedge clk_i) disable iff (!rstn)
        out_vld_i |=> !out_vld_i)
        else $error("vld_o stayed high for two cycles");

    // vld_o is loaded four edges after the last strobe and seen one edge later
    a_latency: assert property (@(posedge clk_i) disable iff (!rstn)
        out_vld_i |-> $past(in_vld_i, 5))
        else $error("vld_o raised without a strobe four cycles before it");

    a_known: assert property (@(posedge clk_i) disable iff (!rstn)
        !$isunknown({in_vld_i, dec_vld_i, mul_vld_i, out_vld_i, acc_i}))
        else $error("unknown value on a strobe or on acc_o after reset");

endmodule

// File: bench/posit_mac_monitor.sv
module posit_mac_monitor
    import posit_pkg::*;
    import mac_pkg::*;
(
    input  logic   clk_i,
    input  logic   rstn,
    input  logic   vld_i,
    input  posit_t w_i,
    input  posit_t d_i,
    input  posit_t acc_i,
    input  logic   out_vld_i,
    input  int     test_id_i,
    output int     checks_o,
    output int     errors_o,
    output int     results_o,
    output int     pending_o
);

    typedef struct packed {
        posit_t value;
        int     due;
        int     test;
    } expect_t;

    expect_t             exp_q[$];
    expect_t             head;
    logic signed [127:0] total = '0;
    logic                nar_seen = 1'b0;
    int                  terms = 0;
    int                  cyc = 0;
    int                  checks = 0;
    int                  errors = 0;
    int                  results = 0;
    posit_t              last_acc = '0;

    assign checks_o  = checks;
    assign errors_o  = errors;
    assign results_o = results;
    assign pending_o = exp_q.size();

    function automatic string test_name(input int id);
        case (id)
            1:       return "dense";
            2:       return "gapped";
            3:       return "saturate";
            4:       return "tiny";
            5:       return "cancel";
            6:       return "nar";
            7:       return "back_to_back";
            default: return "reset_idle";
        endcase
    endfunction

    // signed significand with hidden one, value = sig * 2^(sf - 3)
    function automatic void decode_posit(input posit_t p, output int sig, output int sf);
        logic [7:0]  mag;
        logic [15:0] rest;
        int          run;
        int          k;
        mag = p[7] ? -p : p;
        run = 1;
        while (run < 7 && mag[6-run] == mag[6]) begin
            run++;
        end
        k    = mag[6] ? run - 1 : -run;
        rest = {mag[6:0], 9'b0} << (run + 1);
        sf   = 4 * k + int'(rest[15:14]);
        sig  = p[7] ? -(8 + int'(rest[13:11])) : 8 + int'(rest[13:11]);
        if (p == 8'h00) begin
            sig = 0;
            sf  = 0;
        end
    endfunction

    // exact product scaled by 2^54
    function automatic logic signed [127:0] product_term(input posit_t w, input posit_t d);
        int                  sig_w;
        int                  sf_w;
        int                  sig_d;
        int                  sf_d;
        logic signed [127:0] prod;
        decode_posit(w, sig_w, sf_w);
        decode_posit(d, sig_d, sf_d);
        prod = sig_w * sig_d;
        return prod <<< (sf_w + sf_d + 48);
    endfunction

    // ----------------------------------------------------------
    // exact sum to posit, nearest even on the bit pattern
    // ----------------------------------------------------------
    function automatic posit_t round_to_posit(input logic signed [127:0] sum);
        logic [127:0] mag;
        logic [126:0] frac;
        logic [255:0] bits;
        logic [7:0]   body;
        int           lead;
        int           s;
        int           k;
        int           rlen;
        int           head_bits;
        mag  = sum[127] ? -sum : sum;
        lead = 0;
        if (mag == '0) begin
            return 8'h00;
        end
        for (int i = 0; i < 128; i++) begin
            if (mag[i]) begin
                lead = i;
            end
        end
        s = lead - 54;
        if (s < -MAXPOS_SF) begin
            return 8'h00;
        end
        if (s > MAXPOS_SF) begin
            body = 8'h7f;
        end else begin
            k    = s >>> 2;
            frac = 127'(mag << (127 - lead));
            rlen = (k >= 0) ? k + 2 : 1 - k;
            // regime then two exponent bits
            head_bits = (k >= 0) ? ((1 << (k + 1)) - 1) << 1 : 1;
            head_bits = (head_bits << 2) | (s & 3);
            bits = (256'(head_bits) << (254 - rlen)) | (256'(frac) << (127 - rlen));
            body = {1'b0, bits[255:249]} + 8'(bits[248] & (bits[249] | (|bits[247:0])));
            if (body[7]) begin
                body = 8'h7f;
            end
        end
        return sum[127] ? -body : body;
    endfunction

    always @(posedge clk_i) begin
        cyc = cyc + 1;
        if (rstn && vld_i) begin
            if (w_i == POSIT_NAR || d_i == POSIT_NAR) begin
                nar_seen = 1'b1;
            end else begin
                total = total + product_term(w_i, d_i);
            end
            terms = terms + 1;
            if (terms == K_TERMS) begin
                head.value = nar_seen ? POSIT_NAR : round_to_posit(total);
                head.due   = cyc + 4;
                head.test  = test_id_i;
                exp_q.push_back(head);
                total    = '0;
                nar_seen = 1'b0;
                terms    = 0;
            end
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk_i) begin
        if (rstn && out_vld_i) begin
            if (exp_q.size() == 0) begin
                $display("error: vld_o pulsed with no completed burst at cycle %0d", cyc);
                errors++;
            end else begin
                head = exp_q.pop_front();
                checks++;
                results++;
                if (head.due != cyc) begin
                    $display("error: %s result came at cycle %0d, it was due at cycle %0d",
                             test_name(head.test), cyc, head.due);
                    errors++;
                end
                if (acc_i !== head.value) begin
                    $display("FAILED %s expected %h actual %h",
                             test_name(head.test), head.value, acc_i);
                    errors++;
                end
            end
            last_acc = acc_i;
        end else if (rstn && acc_i !== last_acc) begin
            $display("error: acc_o changed from %h to %h without vld_o", last_acc, acc_i);
            errors++;
            last_acc = acc_i;
        end
    end

endmodule

// File: bench/tb_posit_mac.sv
module tb_posit_mac
    import posit_pkg::*;
    import mac_pkg::*;
;

    localparam int PERIOD   = 100;
    localparam int MAX_GAP  = 3;
    localparam int N_RAND   = 20;
    // saturate 6, tiny 4, cancel 4, nar and follow-up 4
    localparam int N_FIXED  = 18;
    localparam int N_BURSTS = 3 * N_RAND + N_FIXED;

    logic        clk_i;
    logic        rstn;
    logic        vld_i;
    posit_t      w_i;
    posit_t      d_i;
    posit_t      acc_o;
    logic        vld_o;
    int          phase;
    int          test_id;
    int          checks;
    int          errors;
    int          results;
    int          pending;
    int          tb_errors;
    logic [31:0] lcg_state;

    posit_mac posit_mac_i (
        .clk_i (clk_i),
        .rstn  (rstn),
        .vld_i (vld_i),
        .w_i   (w_i),
        .d_i   (d_i),
        .acc_o (acc_o),
        .vld_o (vld_o)
    );

    posit_mac_monitor u_monitor (
        .clk_i     (clk_i),
        .rstn      (rstn),
        .vld_i     (vld_i),
        .w_i       (w_i),
        .d_i       (d_i),
        .acc_i     (acc_o),
        .out_vld_i (vld_o),
        .test_id_i (test_id),
        .checks_o  (checks),
        .errors_o  (errors),
        .results_o (results),
        .pending_o (pending)
    );

    bind posit_mac posit_mac_chk u_chk (
        .clk_i     (clk_i),
        .rstn      (rstn),
        .in_vld_i  (vld_i),
        .dec_vld_i (dec_vld),
        .mul_vld_i (mul_vld),
        .out_vld_i (vld_o),
        .acc_i     (acc_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(PERIOD / 2) clk_i = ~clk_i;
    end

    // watchdog, every term at its longest gap plus margin
    initial begin
        #((N_BURSTS * K_TERMS * (MAX_GAP + 1) + 200) * PERIOD);
        $display("timeout: the run did not finish in the expected time");
        $display("Some tests failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic posit_t rand_posit();
        logic [31:0] r;
        r = next_rand();
        return (r[23:16] == POSIT_NAR) ? 8'h00 : r[23:16];
    endfunction

    // ----------------------------------------------------------
    // stimulus, driven on the falling edge
    // ----------------------------------------------------------
    task automatic drive_term(input posit_t w, input posit_t d, input int max_gap);
        logic [31:0] r;
        int          gap;
        r   = next_rand();
        gap = int'(r[15:0]) % (max_gap + 1);
        repeat (gap) begin
            @(negedge clk_i);
            vld_i = 1'b0;
            w_i   = rand_posit();
            d_i   = rand_posit();
        end
        @(negedge clk_i);
        vld_i   = 1'b1;
        w_i     = w;
        d_i     = d;
        test_id = phase;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk_i);
            vld_i = 1'b0;
        end
    endtask

    task automatic random_burst(input int max_gap);
        repeat (K_TERMS) begin
            drive_term(rand_posit(), rand_posit(), max_gap);
        end
    endtask

    // operands near maxpos, one sign for the whole burst
    task automatic saturate_burst();
        logic [31:0] r;
        logic        neg;
        posit_t      d;
        neg = next_rand() > 32'h8000_0000;
        for (int i = 0; i < K_TERMS; i++) begin
            r = next_rand();
            d = {6'b011111, r[19:18]};
            drive_term({6'b011111, r[17:16]}, neg ? -d : d, MAX_GAP);
        end
    endtask

    task automatic tiny_burst();
        logic [31:0] r;
        posit_t      w;
        posit_t      d;
        for (int i = 0; i < K_TERMS; i++) begin
            r = next_rand();
            w = {6'b0, r[17:16]};
            d = {6'b0, r[19:18]};
            drive_term(r[20] ? -w : w, r[21] ? -d : d, MAX_GAP);
        end
    endtask

    // four pairs that cancel exactly, plus a zero product
    task automatic cancel_burst();
        posit_t w;
        posit_t d;
        for (int i = 0; i < 4; i++) begin
            w = rand_posit();
            d = rand_posit();
            drive_term(w, d, MAX_GAP);
            drive_term(w, -d, MAX_GAP);
        end
        drive_term(rand_posit(), 8'h00, MAX_GAP);
    endtask

    task automatic nar_burst();
        logic [31:0] r;
        int          pos;
        r   = next_rand();
        pos = int'(r[23:16]) % K_TERMS;
        for (int i = 0; i < K_TERMS; i++) begin
            if (i == pos && r[0]) begin
                drive_term(POSIT_NAR, rand_posit(), 1);
            end else if (i == pos) begin
                drive_term(rand_posit(), POSIT_NAR, 1);
            end else begin
                drive_term(rand_posit(), rand_posit(), 1);
            end
        end
    endtask

    initial begin
        lcg_state = 32'hde39be95;
        rstn      = 1'b0;
        vld_i     = 1'b0;
        w_i       = '0;
        d_i       = '0;
        phase     = 0;
        test_id   = 0;
        tb_errors = 0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rstn = 1'b1;
        idle(8);

        phase = 1;
        repeat (N_RAND) random_burst(0);
        phase = 2;
        repeat (N_RAND) random_burst(MAX_GAP);
        phase = 3;
        repeat (6) saturate_burst();
        phase = 4;
        repeat (4) tiny_burst();
        phase = 5;
        repeat (4) cancel_burst();
        phase = 6;
        repeat (2) begin
            nar_burst();
            random_burst(MAX_GAP);
        end
        phase = 7;
        repeat (N_RAND) random_burst(0);
        idle(10);

        if (pending != 0) begin
            $display("error: %0d results never appeared on vld_o", pending);
            tb_errors++;
        end
        if (results != N_BURSTS) begin
            $display("error: %0d results seen, %0d bursts were sent", results, N_BURSTS);
            tb_errors++;
        end
        $display("checks: %0d, errors: %0d", checks, errors + tb_errors);
        if (errors + tb_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: rtl/mac_pkg.sv
package mac_pkg;

    import posit_pkg::*;

    // ----------------------------------------------------------
    // accumulation
    // ----------------------------------------------------------
    localparam int K_TERMS = 9;
    localparam int CNT_W   = $clog2(K_TERMS);

    // product significand 1.ffffff x 1.ffffff
    localparam int PFRAC_W = 2 * FRAC_W;
    localparam int PSIG_W  = 2 * (FRAC_W + 1);

    // quire layout: sign | guard | integer | fraction
    localparam int Q_FRAC  = 2 * MAXPOS_SF + PFRAC_W;
    localparam int Q_INT   = 2 * MAXPOS_SF + 1;
    localparam int Q_GUARD = 4;
    localparam int QUIRE_W = 1 + Q_GUARD + Q_INT + Q_FRAC;

    // shift of the significand for scale 0, one extra bit below the quire lsb
    localparam int Q_SHIFT0 = Q_FRAC - PFRAC_W;
    localparam int SH_W     = $clog2(QUIRE_W + 1);

    typedef logic signed [QUIRE_W-1:0] quire_t;

    // normalized product, value = sig * 2^(sf - PFRAC_W - 1), msb of sig is the hidden one
    typedef struct packed {
        posit_class_e         cls;
        logic                 sign;
        logic signed [SF_W:0] sf;
        logic [PSIG_W-1:0]    sig;
    } prod_t;

endpackage

// File: rtl/posit_decoder.sv
module posit_decoder
    import posit_pkg::*;
(
    input  logic          clk_i,
    input  logic          rstn,
    input  logic          vld_i,
    input  posit_t        p_i,
    output posit_fields_t fields_o
);

    logic [POSIT_W-2:0]          body;
    logic [POSIT_W-2:0]          tail;
    logic [$clog2(POSIT_W):0]    run;
    logic                        run_done;
    logic signed [SF_W-ES-1:0]   regime;
    posit_fields_t               dec;

    // ----------------------------------------------------------
    // regime run, exponent and fraction
    // ----------------------------------------------------------
    always_comb begin
        // negative words are decoded from their two's complement
        body = p_i[POSIT_W-1] ? ~p_i[POSIT_W-2:0] + 1'b1 : p_i[POSIT_W-2:0];

        // leading-run detector from the msb of the body
        run      = '0;
        run_done = 1'b0;
        for (int i = POSIT_W - 2; i >= 0; i--) begin
            if (!run_done && body[i] == body[POSIT_W-2]) begin
                run = run + 1'b1;
            end else begin
                run_done = 1'b1;
            end
        end

        // run of ones gives k = run-1, run of zeros gives k = -run
        regime = body[POSIT_W-2] ? run - 1'b1 : -run;

        // drop regime and terminator, exponent and fraction are left-aligned
        tail = body << (run + 1'b1);

        dec.sign = p_i[POSIT_W-1];
        dec.sf   = {regime, tail[POSIT_W-2 -: ES]};
        dec.frac = tail[POSIT_W-2-ES -: FRAC_W];

        if (p_i == '0) begin
            dec.cls = CLS_ZERO;
        end else if (p_i == POSIT_NAR) begin
            dec.cls = CLS_NAR;
        end else begin
            dec.cls = CLS_NORMAL;
        end
    end

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            fields_o <= '0;
        end else if (vld_i) begin
            fields_o <= dec;
        end
    end

endmodule

// File: rtl/posit_encoder.sv
module posit_encoder
    import posit_pkg::*;
    import mac_pkg::*;
(
    input  logic   clk_i,
    input  logic   rstn,
    input  logic   vld_i,
    input  quire_t sum_i,
    input  logic   nar_i,
    output posit_t acc_o,
    output logic   vld_o
);

    typedef struct packed {
        logic                   nar;
        logic                   neg;
        logic                   zero;
        logic                   ovf;
        logic                   udf;
        logic signed [SF_W-1:0] sf;
        // three fraction bits and one more for rounding
        logic [FRAC_W:0]        frac;
        logic                   sticky;
    } norm_t;

    quire_t             neg_sum;
    logic [QUIRE_W-2:0] mag;
    logic [QUIRE_W-2:0] norm;
    int                 lead;
    int                 scale;
    norm_t              s1_d;
    norm_t              s1_q;
    logic               s1_vld;

    logic signed [SF_W-1:0]  k;
    logic signed [ENC_W-1:0] base;
    logic signed [ENC_W-1:0] rw;
    logic                    lsb;
    logic                    guard;
    logic                    sticky;
    logic [POSIT_W-1:0]      body_r;
    posit_t                  mag_p;
    posit_t                  res;

    // ----------------------------------------------------------
    // stage 1: magnitude, leading one, scale
    // ----------------------------------------------------------
    always_comb begin
        neg_sum = -sum_i;
        mag     = sum_i[QUIRE_W-1] ? neg_sum[QUIRE_W-2:0] : sum_i[QUIRE_W-2:0];

        lead = 0;
        for (int i = 0; i < QUIRE_W - 1; i++) begin
            if (mag[i]) begin
                lead = i;
            end
        end
        scale = lead - Q_FRAC;

        // leading one moved to the msb, hidden bit dropped below
        norm = mag << (QUIRE_W - 2 - lead);

        s1_d.nar    = nar_i;
        s1_d.neg    = sum_i[QUIRE_W-1];
        s1_d.zero   = (mag == '0);
        s1_d.ovf    = !s1_d.zero && (scale > MAXPOS_SF);
        s1_d.udf    = !s1_d.zero && (scale < -MAXPOS_SF);
        s1_d.sf     = SF_W'(scale);
        s1_d.frac   = norm[QUIRE_W-3 -: FRAC_W+1];
        s1_d.sticky = |norm[QUIRE_W-4-FRAC_W:0];
    end

    always_ff @(posedge clk_i) begin
        if (vld_i) begin
            s1_q <= s1_d;
        end
    end

    // ----------------------------------------------------------
    // stage 2: regime build, round to nearest even, saturate
    // ----------------------------------------------------------
    always_comb begin
        k = s1_q.sf >>> ES;
        if (!k[SF_W-1]) begin
            // k+1 ones then a zero
            base = {2'b10, s1_q.sf[ES-1:0], s1_q.frac, {(ENC_W-3-ES-FRAC_W){1'b0}}};
            rw   = base >>> k;
        end else begin
            // -k zeros then a one
            base = {2'b01, s1_q.sf[ES-1:0], s1_q.frac, {(ENC_W-3-ES-FRAC_W){1'b0}}};
            rw   = base >>> (-k - 1);
        end

        lsb    = rw[ENC_W-POSIT_W+1];
        guard  = rw[ENC_W-POSIT_W];
        sticky = |rw[ENC_W-POSIT_W-1:0] | s1_q.sticky;

        body_r = {1'b0, rw[ENC_W-1 -: POSIT_W-1]} + (guard & (lsb | sticky));

        // a carry out of the body would reach the NaR code
        if (s1_q.ovf || body_r[POSIT_W-1]) begin
            mag_p = POSIT_MAXPOS;
        end else begin
            mag_p = body_r;
        end

        if (s1_q.nar) begin
            res = POSIT_NAR;
        end else if (s1_q.zero || s1_q.udf) begin
            res = '0;
        end else if (s1_q.neg) begin
            res = -mag_p;
        end else begin
            res = mag_p;
        end
    end

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            s1_vld <= 1'b0;
            vld_o  <= 1'b0;
            acc_o  <= '0;
        end else begin
            s1_vld <= vld_i;
            vld_o  <= s1_vld;
            if (s1_vld) begin
                acc_o <= res;
            end
        end
    end

endmodule

// File: rtl/posit_mac.sv
module posit_mac
    import posit_pkg::*;
    import mac_pkg::*;
(
    input  logic   clk_i,
    input  logic   rstn,
    input  logic   vld_i,
    input  posit_t w_i,
    input  posit_t d_i,
    output posit_t acc_o,
    output logic   vld_o
);

    posit_fields_t w_fields;
    posit_fields_t d_fields;
    logic          dec_vld;
    prod_t         prod;
    logic          mul_vld;
    quire_t        sum;
    logic          sum_nar;
    logic          sum_vld;

    // ----------------------------------------------------------
    // decode, both operands in parallel
    // ----------------------------------------------------------
    posit_decoder u_dec_w (
        .clk_i    (clk_i),
        .rstn     (rstn),
        .vld_i    (vld_i),
        .p_i      (w_i),
        .fields_o (w_fields)
    );

    posit_decoder u_dec_d (
        .clk_i    (clk_i),
        .rstn     (rstn),
        .vld_i    (vld_i),
        .p_i      (d_i),
        .fields_o (d_fields)
    );

    // strobe alongside the decoded fields
    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            dec_vld <= 1'b0;
        end else begin
            dec_vld <= vld_i;
        end
    end

    // ----------------------------------------------------------
    // multiply, accumulate, encode
    // ----------------------------------------------------------
    posit_mult u_mult (
        .clk_i  (clk_i),
        .rstn   (rstn),
        .vld_i  (dec_vld),
        .a_i    (w_fields),
        .b_i    (d_fields),
        .prod_o (prod),
        .vld_o  (mul_vld)
    );

    quire_acc u_acc (
        .clk_i     (clk_i),
        .rstn      (rstn),
        .vld_i     (mul_vld),
        .prod_i    (prod),
        .sum_o     (sum),
        .nar_o     (sum_nar),
        .sum_vld_o (sum_vld)
    );

    posit_encoder u_enc (
        .clk_i (clk_i),
        .rstn  (rstn),
        .vld_i (sum_vld),
        .sum_i (sum),
        .nar_i (sum_nar),
        .acc_o (acc_o),
        .vld_o (vld_o)
    );

endmodule

// File: rtl/posit_mult.sv
module posit_mult
    import posit_pkg::*;
    import mac_pkg::*;
(
    input  logic          clk_i,
    input  logic          rstn,
    input  logic          vld_i,
    input  posit_fields_t a_i,
    input  posit_fields_t b_i,
    output prod_t         prod_o,
    output logic          vld_o
);

    logic [PSIG_W-1:0] sig_raw;
    logic              sig_ovf;
    prod_t             prod_d;

    always_comb begin
        // 1.fff x 1.fff, result in [1, 4)
        sig_raw = {1'b1, a_i.frac} * {1'b1, b_i.frac};
        sig_ovf = sig_raw[PSIG_W-1];

        prod_d.sign = a_i.sign ^ b_i.sign;
        prod_d.sf   = (SF_W+1)'(a_i.sf) + (SF_W+1)'(b_i.sf) + (SF_W+1)'(sig_ovf);
        // keep every bit, renormalized by moving the binary point
        prod_d.sig  = sig_ovf ? sig_raw : sig_raw << 1;

        if (a_i.cls == CLS_NAR || b_i.cls == CLS_NAR) begin
            prod_d.cls = CLS_NAR;
        end else if (a_i.cls == CLS_ZERO || b_i.cls == CLS_ZERO) begin
            prod_d.cls = CLS_ZERO;
        end else begin
            prod_d.cls = CLS_NORMAL;
        end
    end

    always_ff @(posedge clk_i) begin
        if (vld_i) begin
            prod_o <= prod_d;
        end
    end

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            vld_o <= 1'b0;
        end else begin
            vld_o <= vld_i;
        end
    end

endmodule

// File: rtl/posit_pkg.sv
package posit_pkg;

    // ----------------------------------------------------------
    // posit<8,2> number format
    // ----------------------------------------------------------
    localparam int POSIT_W   = 8;
    localparam int ES        = 2;
    // longest fraction field, reached with a two-bit regime
    localparam int FRAC_W    = POSIT_W - 3 - ES;
    // signed scale, covers +/-24
    localparam int SF_W      = 6;
    // maxpos = useed^(n-2) = 2^24
    localparam int MAXPOS_SF = (1 << ES) * (POSIT_W - 2);

    // encoder working word: body, guard and round bits after the regime shift
    localparam int ENC_W     = 2 * POSIT_W - 2;

    typedef logic [POSIT_W-1:0] posit_t;

    localparam posit_t POSIT_NAR    = {1'b1, {(POSIT_W-1){1'b0}}};
    localparam posit_t POSIT_MAXPOS = {1'b0, {(POSIT_W-1){1'b1}}};

    typedef enum logic [1:0] {
        CLS_ZERO   = 2'd0,
        CLS_NORMAL = 2'd1,
        CLS_NAR    = 2'd2
    } posit_class_e;

    // one decoded operand, value = (-1)^sign * 1.frac * 2^sf
    typedef struct packed {
        posit_class_e           cls;
        logic                   sign;
        logic signed [SF_W-1:0] sf;
        logic [FRAC_W-1:0]      frac;
    } posit_fields_t;

endpackage

// File: rtl/quire_acc.sv
module quire_acc
    import posit_pkg::*;
    import mac_pkg::*;
(
    input  logic   clk_i,
    input  logic   rstn,
    input  logic   vld_i,
    input  prod_t  prod_i,
    output quire_t sum_o,
    output logic   nar_o,
    output logic   sum_vld_o
);

    quire_t            acc_q;
    logic              nar_q;
    logic [CNT_W-1:0]  cnt_q;

    logic [SH_W-1:0]   shamt;
    logic [QUIRE_W:0]  aligned;
    quire_t            term;
    quire_t            acc_next;
    logic              nar_next;
    logic              last;

    // ----------------------------------------------------------
    // align the product to the quire binary point
    // ----------------------------------------------------------
    always_comb begin
        // scale -48 lands one bit below the quire lsb, that bit is always zero
        shamt   = SH_W'(Q_SHIFT0 + int'(prod_i.sf));
        aligned = {{(QUIRE_W+1-PSIG_W){1'b0}}, prod_i.sig} << shamt;

        term = quire_t'(aligned[QUIRE_W:1]);
        if (prod_i.sign) begin
            term = -term;
        end
        if (prod_i.cls != CLS_NORMAL) begin
            term = '0;
        end

        acc_next = acc_q + term;
        nar_next = nar_q | (prod_i.cls == CLS_NAR);
        last     = (cnt_q == CNT_W'(K_TERMS - 1));
    end

    // ----------------------------------------------------------
    // running quire and term count
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            acc_q     <= '0;
            nar_q     <= 1'b0;
            cnt_q     <= '0;
            nar_o     <= 1'b0;
            sum_vld_o <= 1'b0;
        end else begin
            sum_vld_o <= vld_i & last;
            if (vld_i) begin
                if (last) begin
                    // burst done, next strobe starts from an empty quire
                    acc_q <= '0;
                    nar_q <= 1'b0;
                    cnt_q <= '0;
                    nar_o <= nar_next;
                end else begin
                    acc_q <= acc_next;
                    nar_q <= nar_next;
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    // snapshot of the final sum
    always_ff @(posedge clk_i) begin
        if (vld_i && last) begin
            sum_o <= acc_next;
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the posit MAC testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_posit_mac \
    -f verilog.f -o sim_posit_mac > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_posit_mac > sim.log 2>&1
cat sim.log
grep -qx "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verilog.f
rtl/posit_pkg.sv
rtl/mac_pkg.sv
rtl/posit_decoder.sv
rtl/posit_mult.sv
rtl/quire_acc.sv
rtl/posit_encoder.sv
rtl/posit_mac.sv
bench/posit_mac_chk.sv
bench/posit_mac_monitor.sv
bench/tb_posit_mac.sv
